//--- design/sigmoidNumPkg.sv
package sigmoidNumPkg;

	// Field widths along the datapath
	localparam int X_W       = 8;
	localparam int MAG_W     = 8;
	localparam int SLOPE_W   = 4;
	localparam int PARTIAL_W = 10;
	localparam int FUNC_W    = 12;
	localparam int Y_W       = 16;

	// Output word layout, top bit zero, folded sum, sign, constant tail
	localparam int FOLD_W = 11;
	localparam int LOW_W  = 3;

	// Register stages from i_x to o_y
	localparam int PIPE_DEPTH = 6;

	// Stage at which the sign is handed to the offset add
	localparam int SIGN_TAP = 4;

	// Constant low field of every output word
	localparam logic [LOW_W-1:0] OUT_LOW_BITS = 3'b011;

	// Signed input sample
	typedef logic signed [X_W-1:0] xIn_t;

	// Magnitude, -128 maps to 128
	typedef logic [MAG_W-1:0] mag_t;

	// Bit i weights the magnitude shifted left by i
	typedef logic [SLOPE_W-1:0] slope_t;

	// First level of the shift-add tree
	typedef logic [PARTIAL_W-1:0] partial_t;

	// Product and offset sum
	typedef logic [FUNC_W-1:0] func_t;

	typedef logic [Y_W-1:0] yOut_t;

endpackage

//--- design/sigmoidSegPkg.sv
package sigmoidSegPkg;
	import sigmoidNumPkg::*;

	// Eight linear pieces over the magnitude range
	localparam int SEG_COUNT = 8;
	localparam int SEG_W     = $clog2(SEG_COUNT);

	// Segment field sits at magnitude bits 6 to 4
	localparam int SEG_LSB = 4;

	// Weight step between the two slope bit pairs
	localparam int SLOPE_PAIR_SHIFT = 2;

	typedef logic [SEG_W-1:0] segIdx_t;

	// Slope per segment, steepest near zero
	localparam slope_t SEG_SLOPE [SEG_COUNT] = '{
		4'b1111,
		4'b1110,
		4'b1011,
		4'b1000,
		4'b0110,
		4'b0100,
		4'b0010,
		4'b0001
	};

	// Offset per segment, top two bits always 01
	localparam func_t SEG_OFFSET [SEG_COUNT] = '{
		12'h403,
		12'h41D,
		12'h47E,
		12'h50F,
		12'h58B,
		12'h624,
		12'h6E2,
		12'h758
	};

endpackage

//--- design/sigmoidCtrl.sv
`timescale 1ns/1ps

module sigmoidCtrl import sigmoidNumPkg::*; (
	input  logic clk,
	input  logic i_rstN,
	input  logic i_inValid,
	input  logic i_sign,
	output logic o_signS4,
	output logic o_outValid
);

	// Bit k holds the valid of the sample sitting in stage k+1
	logic [PIPE_DEPTH-1:0] validPipe;

	// Sign from stage 1 up to the tap stage
	logic [SIGN_TAP-1:0] signPipe;

	always_ff @(posedge clk or negedge i_rstN) begin
		if (!i_rstN) begin
			validPipe <= '0;
		end else begin
			validPipe <= {validPipe[PIPE_DEPTH-2:0], i_inValid};
		end
	end

	always_ff @(posedge clk or negedge i_rstN) begin
		if (!i_rstN) begin
			signPipe <= '0;
		end else begin
			signPipe <= {signPipe[SIGN_TAP-2:0], i_sign};
		end
	end

	// Lines up with the product entering the offset add
	assign o_signS4 = signPipe[SIGN_TAP-1];

	// One pulse per sample, six stages after entry
	assign o_outValid = validPipe[PIPE_DEPTH-1];

endmodule

//--- design/absInput.sv
`timescale 1ns/1ps

module absInput import sigmoidNumPkg::*; (
	input  logic clk,
	input  logic i_rstN,
	input  xIn_t i_x,
	output mag_t o_mag,
	output logic o_sign
);

	logic negative;
	mag_t negated;
	mag_t magNext;

	assign negative = i_x[X_W-1];

	// Two's complement, -128 wraps to 8'h80 which reads as 128
	assign negated = mag_t'(~i_x) + mag_t'(1);
	assign magNext = negative ? negated : mag_t'(i_x);

	always_ff @(posedge clk or negedge i_rstN) begin
		if (!i_rstN) begin
			o_mag <= '0;
		end else begin
			o_mag <= magNext;
		end
	end

	// Registered by the control module
	assign o_sign = negative;

endmodule

//--- design/segmentLookup.sv
`timescale 1ns/1ps

module segmentLookup import sigmoidNumPkg::*, sigmoidSegPkg::*; (
	input  logic   clk,
	input  logic   i_rstN,
	input  mag_t   i_mag,
	output mag_t   o_mag,
	output slope_t o_slope,
	output func_t  o_offset
);

	logic    overRange;
	segIdx_t segIdx;
	slope_t  slopeNext;
	func_t   offsetNext;

	// 128 only, the top bit alone is set
	assign overRange = i_mag[MAG_W-1];

	// Last segment for 128, otherwise bits 6 to 4
	assign segIdx = overRange ? segIdx_t'(SEG_COUNT - 1) : i_mag[SEG_LSB +: SEG_W];

	// Coefficient tables
	assign slopeNext  = SEG_SLOPE[segIdx];
	assign offsetNext = SEG_OFFSET[segIdx];

	always_ff @(posedge clk or negedge i_rstN) begin
		if (!i_rstN) begin
			o_mag    <= '0;
			o_slope  <= '0;
			o_offset <= '0;
		end else begin
			o_mag    <= i_mag;
			o_slope  <= slopeNext;
			o_offset <= offsetNext;
		end
	end

endmodule

//--- design/shiftAddMul.sv
`timescale 1ns/1ps

module shiftAddMul import sigmoidNumPkg::*, sigmoidSegPkg::*; (
	input  logic   clk,
	input  logic   i_rstN,
	input  mag_t   i_mag,
	input  slope_t i_slope,
	input  func_t  i_offset,
	output func_t  o_product,
	output func_t  o_offset
);

	// Magnitude gated by each slope bit
	mag_t gated [SLOPE_W];

	partial_t pairLow;
	partial_t pairHigh;
	partial_t pairLowR;
	partial_t pairHighR;
	func_t    offsetR;
	func_t    productNext;

	always_comb begin
		for (int i = 0; i < SLOPE_W; i++) begin
			gated[i] = i_slope[i] ? i_mag : '0;
		end
	end

	// First level, each pair is x*b0 + 2*x*b1
	assign pairLow  = partial_t'(gated[0]) + (partial_t'(gated[1]) << 1);
	assign pairHigh = partial_t'(gated[2]) + (partial_t'(gated[3]) << 1);

	always_ff @(posedge clk or negedge i_rstN) begin
		if (!i_rstN) begin
			pairLowR  <= '0;
			pairHighR <= '0;
			offsetR   <= '0;
		end else begin
			pairLowR  <= pairLow;
			pairHighR <= pairHigh;
			offsetR   <= i_offset;
		end
	end

	// Second level, upper pair carries weight 4
	assign productNext = func_t'(pairLowR) + (func_t'(pairHighR) << SLOPE_PAIR_SHIFT);

	always_ff @(posedge clk or negedge i_rstN) begin
		if (!i_rstN) begin
			o_product <= '0;
			o_offset  <= '0;
		end else begin
			o_product <= productNext;
			o_offset  <= offsetR;
		end
	end

endmodule

//--- design/offsetFormat.sv
`timescale 1ns/1ps

module offsetFormat import sigmoidNumPkg::*; (
	input  logic  clk,
	input  logic  i_rstN,
	input  func_t i_product,
	input  func_t i_offset,
	input  logic  i_sign,
	output yOut_t o_y
);

	func_t sumNext;
	func_t sumR;
	logic  signR;

	logic [FOLD_W-1:0] folded;
	yOut_t             yNext;

	// Wraps at 12 bits
	assign sumNext = i_product + i_offset;

	// Sign follows the sum by one stage
	always_ff @(posedge clk or negedge i_rstN) begin
		if (!i_rstN) begin
			sumR  <= '0;
			signR <= 1'b0;
		end else begin
			sumR  <= sumNext;
			signR <= i_sign;
		end
	end

	// Negative inputs give 1 - f(|x|), which is the complement here
	assign folded = sumR[FOLD_W-1:0] ^ {FOLD_W{signR}};

	assign yNext = {1'b0, folded, signR, OUT_LOW_BITS};

	always_ff @(posedge clk or negedge i_rstN) begin
		if (!i_rstN) begin
			o_y <= '0;
		end else begin
			o_y <= yNext;
		end
	end

endmodule

//--- design/sigmoid.sv
`timescale 1ns/1ps

module sigmoid import sigmoidNumPkg::*; (
	input  logic  clk,
	input  logic  i_rstN,
	input  logic  i_inValid,
	input  xIn_t  i_x,
	output yOut_t o_y,
	output logic  o_outValid
);

	// Stage 0 outputs
	logic  signS0;
	mag_t  magS1;

	// Stage 1 outputs
	mag_t   magS2;
	slope_t slopeS2;
	func_t  offsetS2;

	// Stage 2 and 3 outputs
	func_t productS4;
	func_t offsetS4;

	// Sign handed to the offset add
	logic signS4;

	// Valid and sign travel here, data travels below
	sigmoidCtrl sigmoidCtrl_i (
		.clk        (clk),
		.i_rstN     (i_rstN),
		.i_inValid  (i_inValid),
		.i_sign     (signS0),
		.o_signS4   (signS4),
		.o_outValid (o_outValid)
	);

	absInput absInput_i (
		.clk    (clk),
		.i_rstN (i_rstN),
		.i_x    (i_x),
		.o_mag  (magS1),
		.o_sign (signS0)
	);

	segmentLookup segmentLookup_i (
		.clk      (clk),
		.i_rstN   (i_rstN),
		.i_mag    (magS1),
		.o_mag    (magS2),
		.o_slope  (slopeS2),
		.o_offset (offsetS2)
	);

	// Two cycles of multiply
	shiftAddMul shiftAddMul_i (
		.clk       (clk),
		.i_rstN    (i_rstN),
		.i_mag     (magS2),
		.i_slope   (slopeS2),
		.i_offset  (offsetS2),
		.o_product (productS4),
		.o_offset  (offsetS4)
	);

	// Add, then fold the sign into the output word
	offsetFormat offsetFormat_i (
		.clk       (clk),
		.i_rstN    (i_rstN),
		.i_product (productS4),
		.i_offset  (offsetS4),
		.i_sign    (signS4),
		.o_y       (o_y)
	);

endmodule

//--- testbench/sigmoidChecker.sv
`timescale 1ns/1ps

module sigmoidChecker import sigmoidNumPkg::*, sigmoidSegPkg::*; (
	input logic  clk,
	input logic  i_rstN,
	input logic  i_inValid,
	input yOut_t i_y,
	input logic  i_outValid
);

	// Expected results in input order, filled by the testbench
	xIn_t  expX [$];
	yOut_t expY [$];

	// Edge number at which each valid sample was taken
	int   stampQ [$];
	int   edgeCount = 0;
	logic inReset = 1'b1;

	int passCount = 0;
	int failCount = 0;
	int testFails = 0;

	// Folded field per magnitude, for the x and -x pairing
	logic [FOLD_W-1:0] posFold [256];
	logic [FOLD_W-1:0] negFold [256];
	logic              posSeen [256];
	logic              negSeen [256];

	initial begin
		for (int m = 0; m < 256; m++) begin
			posSeen[m] = 1'b0;
			negSeen[m] = 1'b0;
		end
	end

	// Piecewise-linear rule straight from the segment tables
	function automatic yOut_t predictY(input xIn_t x);
		logic    neg;
		mag_t    mag;
		segIdx_t seg;
		int      sum;
		int      fold;
		neg  = x < 0;
		mag  = neg ? mag_t'(-x) : mag_t'(x);
		seg  = (mag >= 128) ? segIdx_t'(SEG_COUNT - 1) : segIdx_t'(mag / 16);
		sum  = (int'(mag) * int'(SEG_SLOPE[seg]) + int'(SEG_OFFSET[seg])) % 4096;
		fold = sum % 2048;
		if (neg) begin
			fold = fold ^ 2047;
		end
		return yOut_t'(fold * 16 + (neg ? 8 : 0) + 3);
	endfunction

	task automatic expectValue(input xIn_t x, input yOut_t y);
		expX.push_back(x);
		expY.push_back(y);
	endtask

	task automatic expectByRule(input xIn_t x);
		expectValue(x, predictY(x));
	endtask

	function automatic int pending();
		return expY.size();
	endfunction

	task automatic finishTest(input string name);
		$display("%s test finished with %0d errors", name, testFails);
		testFails = 0;
	endtask

	task automatic reportError(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		failCount++;
		testFails++;
	endtask

	task automatic checkOutput();
		xIn_t              x;
		yOut_t             want;
		mag_t              mag;
		int                loads;
		int                failsBefore;
		logic [FOLD_W-1:0] fold;
		failsBefore = failCount;
		x    = expX.pop_front();
		want = expY.pop_front();
		// Sampling edge is the first of the register loads
		loads = edgeCount - stampQ.pop_front() + 1;
		mag   = (x < 0) ? mag_t'(-x) : mag_t'(x);
		fold  = i_y[14:4];
		if (loads != PIPE_DEPTH) begin
			reportError($sformatf("x %0d came out after %0d loads", x, loads));
		end
		if (i_y !== want) begin
			reportError($sformatf("x %0d gave y %h, expected %h", x, i_y, want));
		end
		if (i_y[15] !== 1'b0 || i_y[2:0] !== OUT_LOW_BITS || i_y[3] !== (x < 0)) begin
			reportError($sformatf("x %0d gave malformed y %h", x, i_y));
		end
		if (x < 0) begin
			negFold[mag] = fold;
			negSeen[mag] = 1'b1;
			if (posSeen[mag] && fold !== ~posFold[mag]) begin
				reportError($sformatf("x %0d not the complement of +%0d", x, mag));
			end
		end else begin
			posFold[mag] = fold;
			posSeen[mag] = 1'b1;
			if (negSeen[mag] && fold !== ~negFold[mag]) begin
				reportError($sformatf("x %0d not the complement of -%0d", x, mag));
			end
		end
		if (failCount == failsBefore) begin
			passCount++;
		end
	endtask

	always @(posedge clk) begin
		edgeCount = edgeCount + 1;
		inReset   = !i_rstN;
		if (i_rstN && i_inValid) begin
			stampQ.push_back(edgeCount);
		end
	end

	// Outputs are settled by the falling edge
	always @(negedge clk) begin
		if (inReset) begin
			if (i_outValid !== 1'b0 || i_y !== '0) begin
				reportError($sformatf("outputs not clear in reset, valid %b y %h",
					i_outValid, i_y));
			end
		end else if (i_outValid === 1'b1) begin
			if (expY.size() == 0 || stampQ.size() == 0) begin
				$display("Output pulse at %0t ns with no sample in flight", $time);
				failCount++;
				testFails++;
			end else begin
				checkOutput();
			end
		end
	end

endmodule

//--- testbench/tbSigmoid.sv
`timescale 1ns/1ps

module tbSigmoid import sigmoidNumPkg::*; ();

	localparam int RESET_CYCLES  = 16;
	localparam int PATTERN_COUNT = 45;
	localparam int RANDOM_COUNT  = 200;

	// Twice the nominal length of the whole run
	localparam int CYCLE_LIMIT = 2 * (RESET_CYCLES + PATTERN_COUNT + RANDOM_COUNT + PIPE_DEPTH);

	logic  clk;
	logic  rstN;
	logic  inValid;
	xIn_t  xIn;
	yOut_t yOut;
	logic  outValid;

	// Input byte then expected output, two words per sample
	logic [15:0] patternMem [2*PATTERN_COUNT];

	int cycleCount = 0;

	sigmoid sigmoid_i (
		.clk        (clk),
		.i_rstN     (rstN),
		.i_inValid  (inValid),
		.i_x        (xIn),
		.o_y        (yOut),
		.o_outValid (outValid)
	);

	sigmoidChecker sigmoidChecker_i (
		.clk        (clk),
		.i_rstN     (rstN),
		.i_inValid  (inValid),
		.i_y        (yOut),
		.i_outValid (outValid)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Run timed out after %0d cycles", cycleCount);
			$display("Test failed");
			$finish;
		end
	end

	task automatic waitForDrain();
		while (sigmoidChecker_i.pending() != 0) begin
			@(posedge clk);
		end
	endtask

	initial begin
		clk     = 1'b0;
		rstN    = 1'b0;
		inValid = 1'b0;
		xIn     = '0;
		$readmemh("testbench/sigmoidPatterns.hex", patternMem);
		void'($urandom(32'hb369));

		repeat (RESET_CYCLES) @(negedge clk);
		rstN = 1'b1;
		@(posedge clk);
		sigmoidChecker_i.finishTest("reset");

		// One sample per cycle, no gaps
		for (int i = 0; i < PATTERN_COUNT; i++) begin
			@(negedge clk);
			inValid = 1'b1;
			xIn     = xIn_t'(patternMem[2*i][7:0]);
			sigmoidChecker_i.expectValue(xIn, patternMem[2*i+1]);
		end
		@(negedge clk);
		inValid = 1'b0;
		waitForDrain();
		sigmoidChecker_i.finishTest("pattern");

		for (int i = 0; i < RANDOM_COUNT; i++) begin
			@(negedge clk);
			// Valid low about a quarter of the time
			inValid = ($urandom % 4) != 0;
			xIn     = xIn_t'($urandom);
			if (inValid) begin
				sigmoidChecker_i.expectByRule(xIn);
			end
		end
		@(negedge clk);
		inValid = 1'b0;
		waitForDrain();
		// Idle tail so a stray pulse still shows up
		repeat (PIPE_DEPTH + 2) @(posedge clk);
		sigmoidChecker_i.finishTest("random");

		$display("Checks passed: %0d, checks failed: %0d",
			sigmoidChecker_i.passCount, sigmoidChecker_i.failCount);
		if (sigmoidChecker_i.failCount == 0 && sigmoidChecker_i.passCount > 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- testbench/sigmoidPatterns.hex
// Columns: input x as a signed byte, expected o_y as a 16-bit word
// Zero, extremes, both sides of every segment boundary, then mixed values
00 4033
01 4123
FF 3EDB
7F 7D73
80 027B
81 028B
0F 4E43
F1 31BB
10 4FD3
F0 302B
1F 5CF3
E1 230B
20 5DE3
E0 221B
2F 6833
D1 17CB
30 68F3
D0 170B
3F 7073
C1 0F8B
40 70B3
C0 0F4B
4F 7653
B1 09AB
50 7643
B0 09BB
5F 7A03
A1 05FB
60 7A23
A0 05DB
6F 7C03
91 03FB
70 7C83
90 037B
05 44E3
FB 3B1B
2A 64C3
D6 1B3B
64 7AA3
9C 055B
46 72F3
BA 0D0B
18 56D3
E8 292B
78 7D03

//--- all.f
design/sigmoidNumPkg.sv
design/sigmoidSegPkg.sv
design/sigmoidCtrl.sv
design/absInput.sv
design/segmentLookup.sv
design/shiftAddMul.sv
design/offsetFormat.sv
design/sigmoid.sv
testbench/sigmoidChecker.sv
testbench/tbSigmoid.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tbSigmoid
FILELIST  = all.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the simulation output holds the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
